//--- src.f
icache_pkg.sv
icache_ctrl.sv
icache_tag_array.sv
icache_data_array.sv
icache_top.sv
tb_ifill_model.sv
tb_icache.sv

//--- run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator, then scan the log.
verilator --binary --timing --assert --top-module tb_icache -f src.f -o sim_icache &&
    ./obj_dir/sim_icache > sim.log 2>&1 ||
    { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended early"; exit 1; }
exit 0

//--- tb_icache.sv
// Instruction cache testbench.
// Runs directed fetch sequences against the cache with a behavioral
// refill memory, keeps a reference model of tags and round-robin
// pointers, and checks the responses with concurrent assertions.
module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_TESTS    = 6;
    localparam int WAIT_LIMIT = 60; // Cycles allowed for one handshake.
    localparam int INDEX_W    = $clog2(ICACHE_N_SETS);
    localparam int TAG_W      = PADDR_W - INDEX_W;

    logic clk_i;
    logic rstn_i;
    logic cache_enable_i;
    logic flush_i;
    logic ireq_valid_i;
    logic ireq_kill_i;
    logic [PADDR_W-1:0] paddr_i;
    logic mmu_miss_i;
    logic mmu_ex_valid_i;
    logic mmu_ptw_valid_i;
    logic ifill_sent_ack_i;
    logic ifill_resp_valid_i;
    logic [LINE_W-1:0] ifill_resp_data_i;
    logic iresp_valid_o;
    logic iresp_ready_o;
    logic [LINE_W-1:0] iresp_data_o;
    logic treq_valid_o;
    logic replay_valid_o;
    logic ifill_req_valid_o;
    logic [PADDR_W-1:0] ifill_req_addr_o;

    // Reference model of the tag store.
    logic [TAG_W-1:0] m_tag   [ICACHE_N_SETS][ICACHE_N_WAY];
    logic             m_valid [ICACHE_N_SETS][ICACHE_N_WAY];
    int               m_rr    [ICACHE_N_SETS];

    logic               started;
    logic               req_new;  // First cycle of a request.
    logic               exp_hit;
    logic               killed;
    logic               tlb_wait;
    logic [PADDR_W-1:0] cur_addr;
    logic [LINE_W-1:0]  exp_line;
    int treq_count = 0;
    int treq_mark;
    int assert_errors = 0;
    int task_errors;
    int err_mark;
    int n_tests;
    int n_pass;
    int n_fail;

    assign exp_line = {(LINE_W / PADDR_W){cur_addr}};

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        if (treq_valid_o) begin
            treq_count <= treq_count + 1;
        end
    end

    icache_top #(
        .ICACHE_N_WAY  (ICACHE_N_WAY),
        .ICACHE_N_SETS (ICACHE_N_SETS)
    ) u_dut (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .cache_enable_i     (cache_enable_i),
        .flush_i            (flush_i),
        .ireq_valid_i       (ireq_valid_i),
        .ireq_kill_i        (ireq_kill_i),
        .paddr_i            (paddr_i),
        .mmu_miss_i         (mmu_miss_i),
        .mmu_ex_valid_i     (mmu_ex_valid_i),
        .mmu_ptw_valid_i    (mmu_ptw_valid_i),
        .ifill_sent_ack_i   (ifill_sent_ack_i),
        .ifill_resp_valid_i (ifill_resp_valid_i),
        .ifill_resp_data_i  (ifill_resp_data_i),
        .iresp_valid_o      (iresp_valid_o),
        .iresp_ready_o      (iresp_ready_o),
        .iresp_data_o       (iresp_data_o),
        .treq_valid_o       (treq_valid_o),
        .replay_valid_o     (replay_valid_o),
        .ifill_req_valid_o  (ifill_req_valid_o),
        .ifill_req_addr_o   (ifill_req_addr_o)
    );

    tb_ifill_model u_fill (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .ifill_req_valid_i  (ifill_req_valid_o),
        .ifill_req_addr_i   (ifill_req_addr_o),
        .ifill_sent_ack_o   (ifill_sent_ack_i),
        .ifill_resp_valid_o (ifill_resp_valid_i),
        .ifill_resp_data_o  (ifill_resp_data_i)
    );

    a_reset_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !started |-> !(iresp_valid_o || ifill_req_valid_o || treq_valid_o || replay_valid_o))
        else begin
            $display("** Error @%0t: cache output active before the first request", $time);
            assert_errors++;
        end
    a_fill_addr: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ifill_req_valid_o |-> (ifill_req_addr_o == cur_addr))
        else begin
            $display("** Error @%0t: refill address %h, expected %h", $time,
                     ifill_req_addr_o, cur_addr);
            assert_errors++;
        end
    a_resp_data: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (iresp_valid_o && !mmu_ex_valid_i) |-> (iresp_data_o == exp_line))
        else begin
            $display("** Error @%0t: response data %h, expected %h", $time,
                     iresp_data_o, exp_line);
            assert_errors++;
        end
    a_hit_now: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (req_new && exp_hit && !mmu_miss_i) |-> (iresp_valid_o && !ifill_req_valid_o))
        else begin
            $display("** Error @%0t: expected hit on %h", $time, cur_addr);
            assert_errors++;
        end
    a_miss_now: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (req_new && !exp_hit && !mmu_miss_i) |-> ifill_req_valid_o)
        else begin
            $display("** Error @%0t: expected refill request for %h", $time, cur_addr);
            assert_errors++;
        end
    a_ready_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ireq_valid_i |-> !iresp_ready_o)
        else begin
            $display("** Error @%0t: cache ready while a request is pending", $time);
            assert_errors++;
        end
    a_kill_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        killed |-> !iresp_valid_o)
        else begin
            $display("** Error @%0t: response for a killed request", $time);
            assert_errors++;
        end
    a_treq_first: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (iresp_valid_o && tlb_wait && !mmu_ex_valid_i) |-> (treq_count != treq_mark))
        else begin
            $display("** Error @%0t: response before the translation request", $time);
            assert_errors++;
        end
    a_ex_resp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mmu_ex_valid_i |-> (iresp_valid_o && !ifill_req_valid_o))
        else begin
            $display("** Error @%0t: no response to a translation exception", $time);
            assert_errors++;
        end

    function automatic logic predict_hit(logic [PADDR_W-1:0] addr);
        int   idx;
        logic hit;
        idx = int'(addr[INDEX_W-1:0]);
        hit = 1'b0;
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            if (m_valid[idx][w] && (m_tag[idx][w] == addr[PADDR_W-1:INDEX_W])) begin
                hit = 1'b1;
            end
        end
        return hit && cache_enable_i; // Disabled cache never hits on lookup.
    endfunction

    function automatic void model_fill(logic [PADDR_W-1:0] addr);
        int idx;
        idx = int'(addr[INDEX_W-1:0]);
        m_tag[idx][m_rr[idx]]   = addr[PADDR_W-1:INDEX_W];
        m_valid[idx][m_rr[idx]] = 1'b1;
        m_rr[idx]               = (m_rr[idx] + 1) % int'(ICACHE_N_WAY);
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk_i);
        while (!iresp_ready_o && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        if (!iresp_ready_o) begin
            $display("cache not ready after %0d cycles, controller in %s", WAIT_LIMIT,
                     u_dut.u_ctrl.state_q.name());
            task_errors++;
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic send_request(logic [PADDR_W-1:0] addr, logic tlb);
        wait_ready();
        started      = 1'b1;
        cur_addr     = addr;
        exp_hit      = predict_hit(addr);
        paddr_i      = addr;
        mmu_miss_i   = tlb;
        ireq_valid_i = 1'b1;
        req_new      = 1'b1;
    endtask

    task automatic wait_response();
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        while (!got && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            got = iresp_valid_o;
            @(posedge clk_i);
            #1;
            req_new = 1'b0;
            n++;
        end
        ireq_valid_i = 1'b0;
        if (!got) begin
            $display("no response for address %h within %0d cycles, controller in %s",
                     cur_addr, WAIT_LIMIT, u_dut.u_ctrl.state_q.name());
            task_errors++;
        end
    endtask

    task automatic access(logic [PADDR_W-1:0] addr);
        send_request(addr, 1'b0);
        wait_response();
        if (!exp_hit) begin
            model_fill(addr);
        end
    endtask

    task automatic kill_access(logic [PADDR_W-1:0] addr);
        send_request(addr, 1'b0);
        @(posedge clk_i);
        #1;
        req_new      = 1'b0;
        ireq_valid_i = 1'b0;
        ireq_kill_i  = 1'b1;
        killed       = 1'b1;
        @(posedge clk_i);
        #1;
        ireq_kill_i = 1'b0;
        wait_ready(); // Refill drains in KILL.
        killed = 1'b0;
    endtask

    task automatic tlb_access(logic [PADDR_W-1:0] addr);
        tlb_wait  = 1'b1;
        treq_mark = treq_count;
        send_request(addr, 1'b1);
        @(posedge clk_i);
        #1;
        req_new = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        mmu_ptw_valid_i = 1'b1;
        mmu_miss_i      = 1'b0;
        @(posedge clk_i);
        #1;
        mmu_ptw_valid_i = 1'b0;
        wait_response();
        tlb_wait = 1'b0;
        if (!exp_hit) begin
            model_fill(addr);
        end
    endtask

    // Exception one cycle into a TLB_MISS or MISS wait.
    task automatic ex_access(logic [PADDR_W-1:0] addr, logic tlb);
        send_request(addr, tlb);
        @(posedge clk_i);
        #1;
        req_new        = 1'b0;
        mmu_ex_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        mmu_ex_valid_i = 1'b0;
        mmu_miss_i     = 1'b0;
        ireq_valid_i   = 1'b0;
    endtask

    task automatic flush_pulse();
        wait_ready();
        flush_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        for (int s = 0; s < ICACHE_N_SETS; s++) begin
            for (int w = 0; w < ICACHE_N_WAY; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic finish_test(string name);
        int total;
        total = assert_errors + task_errors;
        n_tests++;
        if (total == err_mark) begin
            n_pass++;
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            n_fail++;
            $display("test %0d %s: %0d error(s)", n_tests, name, total - err_mark);
        end
        err_mark = total;
    endtask

    initial begin
        #(N_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", N_TESTS * 200);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk_i           = 1'b0;
        rstn_i          = 1'b0;
        cache_enable_i  = 1'b1;
        flush_i         = 1'b0;
        ireq_valid_i    = 1'b0;
        ireq_kill_i     = 1'b0;
        paddr_i         = '0;
        mmu_miss_i      = 1'b0;
        mmu_ex_valid_i  = 1'b0;
        mmu_ptw_valid_i = 1'b0;
        started         = 1'b0;
        req_new         = 1'b0;
        exp_hit         = 1'b0;
        killed          = 1'b0;
        tlb_wait        = 1'b0;
        cur_addr        = '0;
        treq_mark       = 0;
        task_errors     = 0;
        err_mark        = 0;
        n_tests         = 0;
        n_pass          = 0;
        n_fail          = 0;
        for (int s = 0; s < ICACHE_N_SETS; s++) begin
            m_rr[s] = 0;
            for (int w = 0; w < ICACHE_N_WAY; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (8) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        repeat (4) @(posedge clk_i);
        #1;
        finish_test("reset quiet");

        access(16'h1234);
        access(16'h0a53);
        finish_test("first access refill");

        // Set 5 holds two ways and a third tag evicts by pointer order.
        access(16'h1234);
        access(16'h0105);
        access(16'h0105);
        access(16'h0205);
        access(16'h0205);
        access(16'h0105);
        access(16'h0305);
        access(16'h0305);
        access(16'h0205);
        access(16'h0105);
        access(16'h0205);
        finish_test("hits and round-robin");

        flush_pulse();
        access(16'h1234);
        access(16'h0205);
        access(16'h0205);
        access(16'h0105);
        cache_enable_i = 1'b0; // Victim way already holds this tag.
        access(16'h0205);
        cache_enable_i = 1'b1;
        access(16'h0205);
        access(16'h0105);
        finish_test("flush and disable");

        kill_access(16'h0777);
        access(16'h0777);
        finish_test("kill during miss");

        tlb_access(16'h1234);
        tlb_access(16'h0a53);
        ex_access(16'h0999, 1'b1);
        ex_access(16'h0999, 1'b0);
        access(16'h0999);
        finish_test("tlb miss and exception");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_pass, n_fail, assert_errors + task_errors);
        if (n_fail == 0 && (assert_errors + task_errors) == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tb_ifill_model.sv
// Next-level memory model for the instruction cache refill port.
// Acknowledges a refill request, returns the line after a random delay
// and drops the acknowledge one cycle after the line.
module tb_ifill_model (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           ifill_req_valid_i,
    input  logic [icache_pkg::PADDR_W-1:0] ifill_req_addr_i,
    output logic                           ifill_sent_ack_o,
    output logic                           ifill_resp_valid_o,
    output logic [icache_pkg::LINE_W-1:0]  ifill_resp_data_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;

    integer             seed;
    int                 delay;
    int                 wait_cnt;
    logic               busy;
    logic               req_seen;
    logic [PADDR_W-1:0] addr_seen;
    logic [PADDR_W-1:0] line_addr;

    initial begin
        seed               = 22270;
        ifill_sent_ack_o   = 1'b0;
        ifill_resp_valid_o = 1'b0;
        ifill_resp_data_o  = '0;
    end

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy               = 1'b0;
            wait_cnt           = 0;
            ifill_sent_ack_o   = 1'b0;
            ifill_resp_valid_o = 1'b0;
        end else begin
            req_seen  = ifill_req_valid_i; // Sampled on the edge, driven 1 ns later.
            addr_seen = ifill_req_addr_i;
            #1;
            if (ifill_resp_valid_o) begin
                ifill_resp_valid_o = 1'b0;
                ifill_sent_ack_o   = 1'b0;
            end
            if (busy) begin
                if (wait_cnt == 0) begin
                    ifill_resp_valid_o = 1'b1;
                    ifill_resp_data_o  = {(LINE_W / PADDR_W){line_addr}};
                    busy               = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end else if (req_seen) begin
                line_addr        = addr_seen;
                delay            = 2 + int'($unsigned($random(seed)) % 5); // 2 to 6 cycles.
                wait_cnt         = delay - 1;
                busy             = 1'b1;
                ifill_sent_ack_o = 1'b1;
            end
        end
    end

endmodule

//--- icache_top.sv
// Instruction cache top level.
// Connects the controller, tag store and data store to the core fetch
// port, the TLB handshake and the next-level refill port.
module icache_top #(
    parameter int unsigned ICACHE_N_WAY  = icache_pkg::ICACHE_N_WAY,
    parameter int unsigned ICACHE_N_SETS = icache_pkg::ICACHE_N_SETS
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           cache_enable_i,
    input  logic                           flush_i,
    input  logic                           ireq_valid_i,
    input  logic                           ireq_kill_i,
    input  logic [icache_pkg::PADDR_W-1:0] paddr_i,
    input  logic                           mmu_miss_i,
    input  logic                           mmu_ex_valid_i,
    input  logic                           mmu_ptw_valid_i,
    input  logic                           ifill_sent_ack_i,
    input  logic                           ifill_resp_valid_i,
    input  logic [icache_pkg::LINE_W-1:0]  ifill_resp_data_i,
    output logic                           iresp_valid_o,
    output logic                           iresp_ready_o,
    output logic [icache_pkg::LINE_W-1:0]  iresp_data_o,
    output logic                           treq_valid_o,
    output logic                           replay_valid_o,
    output logic                           ifill_req_valid_o,
    output logic [icache_pkg::PADDR_W-1:0] ifill_req_addr_o
);
    import icache_pkg::*;

    logic [ICACHE_N_WAY-1:0] cline_hit;
    logic [ICACHE_N_WAY-1:0] fill_way;
    logic                    fill_done;
    logic                    cmp_enable;
    logic                    cache_wr_ena;
    logic                    flush_en;
    logic [LINE_W-1:0]       rd_data;

    assign ifill_req_addr_o = paddr_i; // Core holds the address during a miss.
    assign iresp_data_o     = rd_data;

    icache_ctrl #(
        .ICACHE_N_WAY (ICACHE_N_WAY)
    ) u_ctrl (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .cache_enable_i     (cache_enable_i),
        .flush_i            (flush_i),
        .ireq_valid_i       (ireq_valid_i),
        .ireq_kill_i        (ireq_kill_i),
        .mmu_ex_valid_i     (mmu_ex_valid_i),
        .mmu_miss_i         (mmu_miss_i),
        .mmu_ptw_valid_i    (mmu_ptw_valid_i),
        .ifill_resp_valid_i (ifill_resp_valid_i),
        .ifill_sent_ack_i   (ifill_sent_ack_i),
        .fill_done_i        (fill_done),
        .cline_hit_i        (cline_hit),
        .cmp_enable_o       (cmp_enable),
        .cache_rd_ena_o     (),           // Arrays read combinationally.
        .cache_wr_ena_o     (cache_wr_ena),
        .iresp_ready_o      (iresp_ready_o),
        .iresp_valid_o      (iresp_valid_o),
        .treq_valid_o       (treq_valid_o),
        .ifill_req_valid_o  (ifill_req_valid_o),
        .replay_valid_o     (replay_valid_o),
        .flush_en_o         (flush_en)
    );

    icache_tag_array #(
        .ICACHE_N_WAY  (ICACHE_N_WAY),
        .ICACHE_N_SETS (ICACHE_N_SETS)
    ) u_tag_array (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .paddr_i        (paddr_i),
        .cmp_enable_i   (cmp_enable),
        .cache_wr_ena_i (cache_wr_ena),
        .flush_en_i     (flush_en),
        .cline_hit_o    (cline_hit),
        .fill_way_o     (fill_way),
        .fill_done_o    (fill_done)
    );

    icache_data_array #(
        .ICACHE_N_WAY  (ICACHE_N_WAY),
        .ICACHE_N_SETS (ICACHE_N_SETS)
    ) u_data_array (
        .clk_i          (clk_i),
        .paddr_i        (paddr_i),
        .cache_wr_ena_i (cache_wr_ena),
        .fill_way_i     (fill_way),
        .fill_data_i    (ifill_resp_data_i),
        .cline_hit_i    (cline_hit),
        .rd_data_o      (rd_data)
    );

endmodule

//--- icache_data_array.sv
// Instruction cache data store.
// One line per way and set, written whole on a refill into the victim
// way and read through the hit vector of the tag store.
module icache_data_array #(
    parameter int unsigned ICACHE_N_WAY  = icache_pkg::ICACHE_N_WAY,
    parameter int unsigned ICACHE_N_SETS = icache_pkg::ICACHE_N_SETS
) (
    input  logic                           clk_i,
    input  logic [icache_pkg::PADDR_W-1:0] paddr_i,
    input  logic                           cache_wr_ena_i,
    input  logic [ICACHE_N_WAY-1:0]        fill_way_i,
    input  logic [icache_pkg::LINE_W-1:0]  fill_data_i,
    input  logic [ICACHE_N_WAY-1:0]        cline_hit_i,
    output logic [icache_pkg::LINE_W-1:0]  rd_data_o
);
    import icache_pkg::*;

    localparam int unsigned INDEX_W = $clog2(ICACHE_N_SETS);

    logic [INDEX_W-1:0] index;
    logic [LINE_W-1:0]  line_q [ICACHE_N_SETS][ICACHE_N_WAY];

    assign index = paddr_i[INDEX_W-1:0];

    always_ff @(posedge clk_i) begin
        if (cache_wr_ena_i) begin
            for (int w = 0; w < ICACHE_N_WAY; w++) begin
                if (fill_way_i[w]) begin
                    line_q[index][w] <= fill_data_i;
                end
            end
        end
    end

    // Hit vector is at most one-hot, so an OR selects the way.
    always_comb begin
        rd_data_o = '0;
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            if (cline_hit_i[w]) begin
                rd_data_o = rd_data_o | line_q[index][w];
            end
        end
    end

endmodule

//--- icache_tag_array.sv
// Instruction cache tag store.
// Holds tag and valid bit per way and set, compares the indexed set
// against the request, picks the round-robin victim on a refill and
// flags the cycle after a line write.
module icache_tag_array #(
    parameter int unsigned ICACHE_N_WAY  = icache_pkg::ICACHE_N_WAY,
    parameter int unsigned ICACHE_N_SETS = icache_pkg::ICACHE_N_SETS
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic [icache_pkg::PADDR_W-1:0] paddr_i,
    input  logic                           cmp_enable_i,
    input  logic                           cache_wr_ena_i,
    input  logic                           flush_en_i,
    output logic [ICACHE_N_WAY-1:0]        cline_hit_o,
    output logic [ICACHE_N_WAY-1:0]        fill_way_o,
    output logic                           fill_done_o
);
    import icache_pkg::*;

    localparam int unsigned INDEX_W = $clog2(ICACHE_N_SETS);
    localparam int unsigned TAG_W   = PADDR_W - INDEX_W;

    logic [INDEX_W-1:0]      index;
    logic [TAG_W-1:0]        tag;
    logic [TAG_W-1:0]        tag_q   [ICACHE_N_SETS][ICACHE_N_WAY];
    logic [ICACHE_N_WAY-1:0] valid_q [ICACHE_N_SETS];
    logic [ICACHE_N_WAY-1:0] rr_q    [ICACHE_N_SETS]; // One-hot victim pointer.

    assign index = paddr_i[INDEX_W-1:0];
    assign tag   = paddr_i[PADDR_W-1:INDEX_W];

    // Way compare on the indexed set.
    always_comb begin
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            cline_hit_o[w] = cmp_enable_i && valid_q[index][w] && (tag_q[index][w] == tag);
        end
    end

    assign fill_way_o = rr_q[index];

    always_ff @(posedge clk_i) begin
        if (cache_wr_ena_i) begin
            for (int w = 0; w < ICACHE_N_WAY; w++) begin
                if (fill_way_o[w]) begin
                    tag_q[index][w] <= tag;
                end
            end
        end
    end

    // Valid bits, replacement pointers and the write-done flag.
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < ICACHE_N_SETS; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= ICACHE_N_WAY'(1);
            end
            fill_done_o <= 1'b0;
        end else begin
            fill_done_o <= cache_wr_ena_i;
            if (flush_en_i) begin
                for (int s = 0; s < ICACHE_N_SETS; s++) begin
                    valid_q[s] <= '0; // Pointers keep their position.
                end
            end else if (cache_wr_ena_i) begin
                valid_q[index] <= valid_q[index] | rr_q[index];
                rr_q[index]    <= (rr_q[index] << 1) | (rr_q[index] >> (ICACHE_N_WAY - 1));
            end
        end
    end

    // One tag per set at most, since a refill only follows a miss.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(cline_hit_o))
        else $error("icache_tag_array: more than one way hits");

endmodule

//--- icache_ctrl.sv
// Instruction cache controller.
// Sequences lookups, single-beat line refills, TLB walks, replays and
// kills for the one fetch request that the core holds at a time.
module icache_ctrl #(
    parameter int unsigned ICACHE_N_WAY = icache_pkg::ICACHE_N_WAY
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    cache_enable_i,
    input  logic                    flush_i,
    input  logic                    ireq_valid_i,
    input  logic                    ireq_kill_i,
    input  logic                    mmu_ex_valid_i,
    input  logic                    mmu_miss_i,
    input  logic                    mmu_ptw_valid_i,
    input  logic                    ifill_resp_valid_i,
    input  logic                    ifill_sent_ack_i,
    input  logic                    fill_done_i,
    input  logic [ICACHE_N_WAY-1:0] cline_hit_i,
    output logic                    cmp_enable_o,
    output logic                    cache_rd_ena_o,
    output logic                    cache_wr_ena_o,
    output logic                    iresp_ready_o,
    output logic                    iresp_valid_o,
    output logic                    treq_valid_o,
    output logic                    ifill_req_valid_o,
    output logic                    replay_valid_o,
    output logic                    flush_en_o
);
    import icache_pkg::*;

    logic         new_request;
    logic         is_hit;
    logic         is_hit_or_excpt;
    logic         is_flush_or_kill;
    ictrl_state_t state_d;
    ictrl_state_t state_q;

    // A refill beat takes priority over a core request.
    assign new_request      = ireq_valid_i & ~ifill_resp_valid_i;
    assign is_hit           = |cline_hit_i;
    assign is_hit_or_excpt  = is_hit | mmu_ex_valid_i;
    assign is_flush_or_kill = flush_i | ireq_kill_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= NO_REQ;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d           = state_q;
        cmp_enable_o      = 1'b0;
        cache_rd_ena_o    = 1'b0;
        cache_wr_ena_o    = 1'b0;
        iresp_ready_o     = 1'b0;
        iresp_valid_o     = 1'b0;
        treq_valid_o      = 1'b0;
        ifill_req_valid_o = 1'b0;
        replay_valid_o    = 1'b0;
        flush_en_o        = 1'b0;

        case (state_q)
            READ: begin
                cmp_enable_o  = cache_enable_i;
                iresp_ready_o = !new_request;
                flush_en_o    = flush_i;
                if (new_request && !is_flush_or_kill) begin
                    if (mmu_miss_i) begin
                        state_d = TLB_MISS; // Translation not there yet.
                    end else if (is_hit_or_excpt) begin
                        iresp_valid_o = 1'b1; // Hit or exception, answered now.
                    end else begin
                        ifill_req_valid_o = 1'b1;
                        state_d           = MISS;
                    end
                end
            end
            MISS: begin
                iresp_valid_o = mmu_ex_valid_i;
                flush_en_o    = flush_i;
                // The refill line lands in the victim way unless it was abandoned.
                cache_wr_ena_o = ifill_resp_valid_i && !is_flush_or_kill && !mmu_ex_valid_i;
                if (is_flush_or_kill || mmu_ex_valid_i) begin
                    state_d = KILL;
                end else if (fill_done_i) begin
                    state_d = REPLAY;
                end
            end
            TLB_MISS: begin
                iresp_valid_o = mmu_ex_valid_i;
                flush_en_o    = flush_i;
                if (is_flush_or_kill || mmu_ex_valid_i) begin
                    state_d = READ;
                end else if (mmu_ptw_valid_i) begin
                    state_d = REPLAY_TLB; // Walk finished.
                end else if (!mmu_miss_i) begin
                    state_d = READ;
                end
            end
            REPLAY: begin
                // Compare is forced on, so a disabled cache still returns the fresh line.
                cmp_enable_o   = 1'b1;
                cache_rd_ena_o = !is_flush_or_kill && !mmu_ex_valid_i;
                replay_valid_o = !is_flush_or_kill && !mmu_ex_valid_i;
                flush_en_o     = flush_i;
                iresp_valid_o  = mmu_ex_valid_i ||
                                 (!cache_enable_i && is_hit && new_request && !is_flush_or_kill);
                state_d        = READ;
            end
            KILL: begin
                iresp_valid_o = mmu_ex_valid_i;
                // Outstanding refill is drained, its data is dropped.
                if (!ifill_sent_ack_i) begin
                    state_d = READ;
                end
            end
            REPLAY_TLB: begin
                iresp_valid_o  = mmu_ex_valid_i;
                cache_rd_ena_o = !is_flush_or_kill && !mmu_ex_valid_i;
                treq_valid_o   = !is_flush_or_kill && !mmu_ex_valid_i;
                replay_valid_o = 1'b1;
                flush_en_o     = flush_i;
                state_d        = READ;
            end
            default: begin
                state_d = READ; // Leave NO_REQ after reset.
            end
        endcase
    end

    // A refill request and a response never share a cycle.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(ifill_req_valid_o && iresp_valid_o))
        else $error("icache_ctrl: refill request and response in one cycle");

    // Lines are written only while a refill is awaited.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        cache_wr_ena_o |-> (state_q == MISS))
        else $error("icache_ctrl: line write outside MISS");

endmodule

//--- icache_pkg.sv
// Instruction cache package.
// Controller state encoding, address and line widths, and the default
// geometry used by the cache top level.
package icache_pkg;

    // Physical line address presented by the fetch stage.
    localparam int unsigned PADDR_W = 16;

    // One cache line, returned whole on a hit and on a refill.
    localparam int unsigned LINE_W = 64;

    // Default geometry.
    localparam int unsigned ICACHE_N_WAY  = 2;
    localparam int unsigned ICACHE_N_SETS = 8;

    // Controller states.
    typedef enum logic [2:0] {
        NO_REQ     = 3'd0, // Out of reset, no lookup yet.
        READ       = 3'd1, // Lookup of a new request.
        MISS       = 3'd2, // Waiting for the refill line.
        TLB_MISS   = 3'd3, // Waiting for the page-table walker.
        REPLAY     = 3'd4, // Line written, lookup is repeated.
        KILL       = 3'd5, // Draining a refill nobody wants.
        REPLAY_TLB = 3'd6  // Walk done, translation asked again.
    } ictrl_state_t;

endpackage
